/* verilog/s86_video_pkg.sv */
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Shared widths and colour definitions for the System 86 video path
////////////////////////////////////////////////////////////////////////////

package s86_video_pkg;

	// Colour index from the dot generator
	localparam int DOT_W = 8;
	// Palette address, bank bit on top of the dot
	localparam int PAL_ADDR_W = DOT_W + 1;
	// Native component width of the board DACs
	localparam int COMP_W = 4;

	// 49.125 MHz master clock, 6.14 MHz pixel rate
	localparam int CLK_DIV = 8;
	localparam int DIV_W = $clog2(CLK_DIV);

	// One palette entry, red in the top nibble
	typedef struct packed {
		logic [COMP_W-1:0] red;
		logic [COMP_W-1:0] green;
		logic [COMP_W-1:0] blue;
	} color_t;

	// Blanked colour
	localparam color_t COLOR_BLACK = '{red: '0, green: '0, blue: '0};

endpackage

`default_nettype wire

/* verilog/video_timing.sv */
`timescale 1ns/10ps
`default_nettype none

module video_timing
	import s86_video_pkg::*;
	#(
		parameter int H_ACTIVE = 288,
		parameter int H_TOTAL = 384,
		parameter int V_ACTIVE = 224,
		parameter int V_TOTAL = 264
	)
	(
		input wire i_clk,
		input wire i_arst_n,
		output logic o_pix_ce,
		output logic [9:0] o_h_cnt,
		output logic [9:0] o_v_cnt,
		output logic o_active,
		output logic o_hsync_n,
		output logic o_vsync_n,
		output logic o_hblank_n,
		output logic o_vblank_n
	);

	// Sync pulses sit inside the blanking intervals
	localparam int HS_START = H_ACTIVE + 32;
	localparam int HS_END = HS_START + 32;
	localparam int VS_START = V_ACTIVE + 16;
	localparam int VS_END = VS_START + 3;

	logic [DIV_W-1:0] div_cnt;
	logic [9:0] h_next;
	logic [9:0] v_next;

	////////////////////////////////////////////////////////////////////////////
	// Pixel strobe
	////////////////////////////////////////////////////////////////////////////

	// Master clock divided by eight, strobe one cycle wide
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			div_cnt <= '0;
			o_pix_ce <= 1'b0;
		end else begin
			if (div_cnt == DIV_W'(CLK_DIV - 1))
				div_cnt <= '0;
			else
				div_cnt <= div_cnt + 1'b1;
			o_pix_ce <= (div_cnt == DIV_W'(CLK_DIV - 1));
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Position counters and levels
	////////////////////////////////////////////////////////////////////////////

	// Next raster position
	always_comb begin
		h_next = o_h_cnt + 10'd1;
		v_next = o_v_cnt;
		if (o_h_cnt == 10'(H_TOTAL - 1)) begin
			h_next = '0;
			// End of line, step the row
			if (o_v_cnt == 10'(V_TOTAL - 1))
				v_next = '0;
			else
				v_next = o_v_cnt + 10'd1;
		end
	end

	// Levels compare on the next position so they stay in step with the counts
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_h_cnt <= '0;
			o_v_cnt <= '0;
			o_active <= 1'b1;
			o_hsync_n <= 1'b1;
			o_vsync_n <= 1'b1;
			o_hblank_n <= 1'b1;
			o_vblank_n <= 1'b1;
		end else if (o_pix_ce) begin
			o_h_cnt <= h_next;
			o_v_cnt <= v_next;
			o_active <= (h_next < 10'(H_ACTIVE)) && (v_next < 10'(V_ACTIVE));
			o_hblank_n <= (h_next < 10'(H_ACTIVE));
			o_vblank_n <= (v_next < 10'(V_ACTIVE));
			o_hsync_n <= !((h_next >= 10'(HS_START)) && (h_next < 10'(HS_END)));
			o_vsync_n <= !((v_next >= 10'(VS_START)) && (v_next < 10'(VS_END)));
		end
	end

	// Strobe never lasts two cycles
	a_ce_single: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		o_pix_ce |=> !o_pix_ce);

	// Counters stay inside the frame
	a_cnt_range: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		(o_h_cnt < 10'(H_TOTAL)) && (o_v_cnt < 10'(V_TOTAL)));

endmodule

`default_nettype wire

/* verilog/dot_pattern.sv */
`timescale 1ns/10ps
`default_nettype none

module dot_pattern
	import s86_video_pkg::*;
	#(
		parameter int V_ACTIVE = 224
	)
	(
		input wire i_clk,
		input wire i_arst_n,
		input wire i_pix_ce,
		input wire [9:0] i_h_cnt,
		input wire [9:0] i_v_cnt,
		input wire i_active,
		output logic [DOT_W-1:0] o_dot,
		output logic o_bank
	);

	// Ramp accumulators, top bits form the index
	localparam int ACC_W = 16;
	localparam int ROW_BITS = 3;
	localparam logic [ACC_W-1:0] COL_STEP = 16'd228;
	localparam logic [ACC_W-1:0] ROW_STEP = 16'd590;
	// Second half of the screen restarts the ramp in the upper bank
	localparam logic [9:0] BANK_ROW = 10'(V_ACTIVE / 2);

	logic [ACC_W-1:0] col_acc;
	logic [ACC_W-1:0] row_acc;
	logic [ACC_W-1:0] col_next;
	logic [ACC_W-1:0] row_next;

	always_comb begin
		col_next = col_acc + COL_STEP;
		row_next = row_acc;
		// Row step happens once, at the left edge
		if (i_h_cnt == 10'd0) begin
			col_next = '0;
			if ((i_v_cnt == 10'd0) || (i_v_cnt == BANK_ROW))
				row_next = '0;
			else
				row_next = row_acc + ROW_STEP;
		end
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			col_acc <= '0;
			row_acc <= '0;
			o_dot <= '0;
			o_bank <= 1'b0;
		end else if (i_pix_ce) begin
			col_acc <= col_next;
			row_acc <= row_next;
			// Row ramp above column ramp, black outside the picture
			if (i_active)
				o_dot <= {row_next[ACC_W-1 -: ROW_BITS], col_next[ACC_W-1 -: DOT_W-ROW_BITS]};
			else
				o_dot <= '0;
			// Bank flips with the same strobe as the dot of that row
			if (i_v_cnt == BANK_ROW)
				o_bank <= 1'b1;
			else if (i_v_cnt == 10'd0)
				o_bank <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* verilog/palette_lut.sv */
`timescale 1ns/10ps
`default_nettype none

module palette_lut
	import s86_video_pkg::*;
	(
		input wire i_clk,
		input wire i_arst_n,
		input wire i_pix_ce,
		input wire [DOT_W-1:0] i_dot,
		input wire i_bank,
		input wire i_pal_we,
		input wire [PAL_ADDR_W-1:0] i_pal_addr,
		input wire color_t i_pal_data,
		output color_t o_color
	);

	localparam int PAL_DEPTH = 2 ** PAL_ADDR_W;

	// Colour RAM in place of the 3R/3S PROM pair
	color_t pal_mem [PAL_DEPTH];
	logic [PAL_ADDR_W-1:0] rd_addr;

	// Bank selects the upper or lower 256 entries
	assign rd_addr = {i_bank, i_dot};

	////////////////////////////////////////////////////////////////////////////
	// Write port
	////////////////////////////////////////////////////////////////////////////

	// Host write, any cycle, visible from the next edge
	always_ff @(posedge i_clk) begin
		if (i_pal_we)
			pal_mem[i_pal_addr] <= i_pal_data;
	end

	////////////////////////////////////////////////////////////////////////////
	// Lookup
	////////////////////////////////////////////////////////////////////////////

	// One strobe behind the dot
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n)
			o_color <= COLOR_BLACK;
		else if (i_pix_ce)
			o_color <= pal_mem[rd_addr];
	end

	// Every palette write lands on a known entry
	a_we_addr_known: assert property (@(posedge i_clk)
		i_pal_we |-> !$isunknown(i_pal_addr));

endmodule

`default_nettype wire

/* verilog/video_out.sv */
`timescale 1ns/10ps
`default_nettype none

module video_out
	import s86_video_pkg::*;
	#(
		parameter int VIDEO_COMPONENT_DEPTH = 8
	)
	(
		input wire i_clk,
		input wire i_arst_n,
		input wire i_pix_ce,
		input wire color_t i_color,
		input wire i_hsync_n,
		input wire i_vsync_n,
		input wire i_hblank_n,
		input wire i_vblank_n,
		output logic [COMP_W-1:0] o_red,
		output logic [COMP_W-1:0] o_green,
		output logic [COMP_W-1:0] o_blue,
		output logic o_csync_n,
		output logic [VIDEO_COMPONENT_DEPTH-1:0] o_vid_red,
		output logic [VIDEO_COMPONENT_DEPTH-1:0] o_vid_green,
		output logic [VIDEO_COMPONENT_DEPTH-1:0] o_vid_blue,
		output logic o_vid_hsync_n,
		output logic o_vid_vsync_n,
		output logic o_vid_hblank_n,
		output logic o_vid_vblank_n,
		output logic o_vid_ce
	);

	// Strobes before the first real pixel reaches the output
	localparam logic [1:0] FILL_STROBES = 2'd2;

	// Level taps, {hsync_n, vsync_n, hblank_n, vblank_n}
	logic [3:0] lvl_d1;
	logic [3:0] lvl_d2;
	logic [3:0] lvl_d3;
	color_t color_q;
	logic [1:0] fill_cnt;

	// Nibble repeated from the top down, partial copy takes its upper bits
	function automatic logic [VIDEO_COMPONENT_DEPTH-1:0] widen(input logic [COMP_W-1:0] nib);
		logic [VIDEO_COMPONENT_DEPTH-1:0] wide;
		for (int i = 0; i < VIDEO_COMPONENT_DEPTH; i++)
			wide[VIDEO_COMPONENT_DEPTH-1-i] = nib[COMP_W-1-(i % COMP_W)];
		return wide;
	endfunction

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			lvl_d1 <= '1;
			lvl_d2 <= '1;
			lvl_d3 <= '1;
			color_q <= COLOR_BLACK;
			fill_cnt <= '0;
			o_vid_ce <= 1'b0;
		end else begin
			// Output clock enable once the pipeline holds real pixels
			o_vid_ce <= i_pix_ce && (fill_cnt == FILL_STROBES);
			if (i_pix_ce) begin
				lvl_d1 <= {i_hsync_n, i_vsync_n, i_hblank_n, i_vblank_n};
				lvl_d2 <= lvl_d1;
				lvl_d3 <= lvl_d2;
				if (fill_cnt != FILL_STROBES)
					fill_cnt <= fill_cnt + 2'd1;
				// Second tap belongs to the pixel now in the palette register
				if (lvl_d2[1] && lvl_d2[0])
					color_q <= i_color;
				else
					color_q <= COLOR_BLACK;
			end
		end
	end

	// Native connector outputs
	assign o_red = color_q.red;
	assign o_green = color_q.green;
	assign o_blue = color_q.blue;
	assign o_csync_n = lvl_d3[3] & lvl_d3[2];

	// Simulation outputs
	assign o_vid_red = widen(color_q.red);
	assign o_vid_green = widen(color_q.green);
	assign o_vid_blue = widen(color_q.blue);
	assign o_vid_hsync_n = lvl_d3[3];
	assign o_vid_vsync_n = lvl_d3[2];
	assign o_vid_hblank_n = lvl_d3[1];
	assign o_vid_vblank_n = lvl_d3[0];

endmodule

`default_nettype wire

/* verilog/system86_video.sv */
`timescale 1ns/10ps
`default_nettype none

module system86_video
	import s86_video_pkg::*;
	#(
		parameter int H_ACTIVE = 288,
		parameter int H_TOTAL = 384,
		parameter int V_ACTIVE = 224,
		parameter int V_TOTAL = 264,
		parameter int VIDEO_COMPONENT_DEPTH = 8
	)
	(
		input wire i_clk,
		input wire i_arst_n,
		// Palette load port
		input wire i_pal_we,
		input wire [PAL_ADDR_W-1:0] i_pal_addr,
		input wire color_t i_pal_data,
		// Native RGB and composite sync
		output logic [COMP_W-1:0] o_red,
		output logic [COMP_W-1:0] o_green,
		output logic [COMP_W-1:0] o_blue,
		output logic o_csync_n,
		// Widened video for the simulation frame grabber
		output logic [VIDEO_COMPONENT_DEPTH-1:0] o_vid_red,
		output logic [VIDEO_COMPONENT_DEPTH-1:0] o_vid_green,
		output logic [VIDEO_COMPONENT_DEPTH-1:0] o_vid_blue,
		output logic o_vid_hsync_n,
		output logic o_vid_vsync_n,
		output logic o_vid_hblank_n,
		output logic o_vid_vblank_n,
		output logic o_vid_ce
	);

	logic pix_ce;
	logic [9:0] h_cnt;
	logic [9:0] v_cnt;
	logic active;
	logic hsync_n;
	logic vsync_n;
	logic hblank_n;
	logic vblank_n;
	logic [DOT_W-1:0] dot;
	logic bank;
	color_t pix_color;

	////////////////////////////////////////////////////////////////////////////
	// Timing and dot generation
	////////////////////////////////////////////////////////////////////////////

	video_timing #(
		.H_ACTIVE(H_ACTIVE),
		.H_TOTAL(H_TOTAL),
		.V_ACTIVE(V_ACTIVE),
		.V_TOTAL(V_TOTAL)
	) u_video_timing (
		.i_clk(i_clk),
		.i_arst_n(i_arst_n),
		.o_pix_ce(pix_ce),
		.o_h_cnt(h_cnt),
		.o_v_cnt(v_cnt),
		.o_active(active),
		.o_hsync_n(hsync_n),
		.o_vsync_n(vsync_n),
		.o_hblank_n(hblank_n),
		.o_vblank_n(vblank_n)
	);

	// Test ramp stands in for the tile and sprite mixers
	dot_pattern #(
		.V_ACTIVE(V_ACTIVE)
	) u_dot_pattern (
		.i_clk(i_clk),
		.i_arst_n(i_arst_n),
		.i_pix_ce(pix_ce),
		.i_h_cnt(h_cnt),
		.i_v_cnt(v_cnt),
		.i_active(active),
		.o_dot(dot),
		.o_bank(bank)
	);

	////////////////////////////////////////////////////////////////////////////
	// Palette and output stage
	////////////////////////////////////////////////////////////////////////////

	palette_lut u_palette_lut (
		.i_clk(i_clk),
		.i_arst_n(i_arst_n),
		.i_pix_ce(pix_ce),
		.i_dot(dot),
		.i_bank(bank),
		.i_pal_we(i_pal_we),
		.i_pal_addr(i_pal_addr),
		.i_pal_data(i_pal_data),
		.o_color(pix_color)
	);

	video_out #(
		.VIDEO_COMPONENT_DEPTH(VIDEO_COMPONENT_DEPTH)
	) u_video_out (
		.i_clk(i_clk),
		.i_arst_n(i_arst_n),
		.i_pix_ce(pix_ce),
		.i_color(pix_color),
		.i_hsync_n(hsync_n),
		.i_vsync_n(vsync_n),
		.i_hblank_n(hblank_n),
		.i_vblank_n(vblank_n),
		.o_red(o_red),
		.o_green(o_green),
		.o_blue(o_blue),
		.o_csync_n(o_csync_n),
		.o_vid_red(o_vid_red),
		.o_vid_green(o_vid_green),
		.o_vid_blue(o_vid_blue),
		.o_vid_hsync_n(o_vid_hsync_n),
		.o_vid_vsync_n(o_vid_vsync_n),
		.o_vid_hblank_n(o_vid_hblank_n),
		.o_vid_vblank_n(o_vid_vblank_n),
		.o_vid_ce(o_vid_ce)
	);

endmodule

`default_nettype wire

/* sim/tb_system86_video.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_system86_video
	import s86_video_pkg::*;
	();

	// Raster of the board
	localparam int H_ACTIVE = 288;
	localparam int H_TOTAL = 384;
	localparam int V_ACTIVE = 224;
	localparam int V_TOTAL = 264;
	localparam int VS_LINES = 3;
	localparam int COMP_DEPTH = 8;
	localparam int REP_COPIES = (COMP_DEPTH + COMP_W - 1) / COMP_W;
	localparam int RESET_CYCLES = 10;
	localparam int FRAME_PIXELS = H_TOTAL * V_TOTAL;
	// Two frames of master cycles plus some slack for reset and fill
	localparam int WATCHDOG_CYCLES = 2 * FRAME_PIXELS * CLK_DIV + 1000;
	localparam string GOLDEN_FILE = "sim/system86_video_golden.txt";

	logic i_clk;
	logic i_arst_n;
	logic i_pal_we;
	logic [PAL_ADDR_W-1:0] i_pal_addr;
	color_t i_pal_data;
	logic [COMP_W-1:0] o_red;
	logic [COMP_W-1:0] o_green;
	logic [COMP_W-1:0] o_blue;
	logic o_csync_n;
	logic [COMP_DEPTH-1:0] o_vid_red;
	logic [COMP_DEPTH-1:0] o_vid_green;
	logic [COMP_DEPTH-1:0] o_vid_blue;
	logic o_vid_hsync_n;
	logic o_vid_vsync_n;
	logic o_vid_hblank_n;
	logic o_vid_vblank_n;
	logic o_vid_ce;

	// Palette loads and expected colours, keyed by active pixel index
	logic [PAL_ADDR_W-1:0] wr_addr_q [$];
	color_t wr_data_q [$];
	color_t gold_color [int];
	int gold_upper;
	// Output tracking
	int pix_cnt;
	int act_idx;
	int seen_cnt;
	int hs_falls;
	int vs_falls;
	int vs_lines;
	logic hs_prev;
	logic vs_prev;
	logic started;

	system86_video #(
		.H_ACTIVE(H_ACTIVE),
		.H_TOTAL(H_TOTAL),
		.V_ACTIVE(V_ACTIVE),
		.V_TOTAL(V_TOTAL),
		.VIDEO_COMPONENT_DEPTH(COMP_DEPTH)
	) uut (
		.i_clk(i_clk),
		.i_arst_n(i_arst_n),
		.i_pal_we(i_pal_we),
		.i_pal_addr(i_pal_addr),
		.i_pal_data(i_pal_data),
		.o_red(o_red),
		.o_green(o_green),
		.o_blue(o_blue),
		.o_csync_n(o_csync_n),
		.o_vid_red(o_vid_red),
		.o_vid_green(o_vid_green),
		.o_vid_blue(o_vid_blue),
		.o_vid_hsync_n(o_vid_hsync_n),
		.o_vid_vsync_n(o_vid_vsync_n),
		.o_vid_hblank_n(o_vid_hblank_n),
		.o_vid_vblank_n(o_vid_vblank_n),
		.o_vid_ce(o_vid_ce)
	);

	// 100 MHz testbench clock
	initial begin
		i_clk = 1'b0;
		forever #5 i_clk = ~i_clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic fail_stop(input string msg);
		$display("%s", msg);
		$display("TESTS FAILED");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_color(input color_t got, input color_t exp, input string what);
		if (got !== exp)
			fail_stop($sformatf("[FAIL] %0t ns: %s colour %h, expected %h",
				$time, what, got, exp));
	endtask

	task automatic check_level(input logic got, input logic exp, input string what);
		if (got !== exp)
			fail_stop($sformatf("[FAIL] %0t ns: %s is %b, expected %b", $time, what, got, exp));
	endtask

	task automatic check_wide(input logic [COMP_DEPTH-1:0] got,
		input logic [COMP_DEPTH-1:0] exp, input string what);
		if (got !== exp)
			fail_stop($sformatf("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp));
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp)
			fail_stop($sformatf("[FAIL] %0t ns: %s %0d, expected %0d", $time, what, got, exp));
	endtask

	// Nibble copies side by side, top bits kept
	function automatic logic [COMP_DEPTH-1:0] expand_component(input logic [COMP_W-1:0] nib);
		logic [REP_COPIES*COMP_W-1:0] rep;
		rep = {REP_COPIES{nib}};
		return rep[REP_COPIES*COMP_W-1 -: COMP_DEPTH];
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Golden file and reset
	////////////////////////////////////////////////////////////////////////////

	task automatic load_golden();
		int fd;
		int rc;
		int row;
		int col;
		int addr;
		int data;
		string line;
		fd = $fopen(GOLDEN_FILE, "r");
		if (fd == 0)
			fail_stop({"Cannot open the golden file ", GOLDEN_FILE});
		while (!$feof(fd)) begin
			line = "";
			rc = $fgets(line, fd);
			if ((rc > 0) && (line.getc(0) != "#")) begin
				if ($sscanf(line, "W %h %h", addr, data) == 2) begin
					wr_addr_q.push_back(addr[PAL_ADDR_W-1:0]);
					wr_data_q.push_back(color_t'(data[11:0]));
				end else if ($sscanf(line, "C %d %d %h", row, col, data) == 3) begin
					if ((row < 0) || (row >= V_ACTIVE) || (col < 0) || (col >= H_ACTIVE))
						fail_stop($sformatf("Golden sample at row %0d column %0d is off screen",
							row, col));
					gold_color[row * H_ACTIVE + col] = color_t'(data[11:0]);
					// Rows from the bank row down read the upper palette half
					if (row >= V_ACTIVE / 2)
						gold_upper++;
				end
			end
		end
		$fclose(fd);
		if (gold_color.num() == 0)
			fail_stop("The golden file holds no pixel samples");
		if ((gold_upper == 0) || (gold_upper == gold_color.num()))
			fail_stop("The golden samples do not cover both palette banks");
	endtask

	// Sync and blank idle high
	task automatic check_levels_idle(input string what);
		check_level(o_vid_hsync_n, 1'b1, {"o_vid_hsync_n ", what});
		check_level(o_vid_vsync_n, 1'b1, {"o_vid_vsync_n ", what});
		check_level(o_vid_hblank_n, 1'b1, {"o_vid_hblank_n ", what});
		check_level(o_vid_vblank_n, 1'b1, {"o_vid_vblank_n ", what});
		check_level(o_csync_n, 1'b1, {"o_csync_n ", what});
	endtask

	task automatic check_reset_state();
		check_levels_idle("in reset");
		check_level(o_vid_ce, 1'b0, "o_vid_ce in reset");
		check_color({o_red, o_green, o_blue}, '0, "Reset");
		check_wide(o_vid_red, '0, "o_vid_red in reset");
		check_wide(o_vid_green, '0, "o_vid_green in reset");
		check_wide(o_vid_blue, '0, "o_vid_blue in reset");
	endtask

	// Palette writes on falling edges, reset held at least ten cycles
	task automatic reset_and_load();
		int cyc;
		cyc = 0;
		while ((cyc < RESET_CYCLES) || (wr_addr_q.size() != 0)) begin
			@(negedge i_clk);
			check_reset_state();
			if (wr_addr_q.size() != 0) begin
				i_pal_we = 1'b1;
				i_pal_addr = wr_addr_q.pop_front();
				i_pal_data = wr_data_q.pop_front();
			end else begin
				i_pal_we = 1'b0;
			end
			cyc++;
		end
		@(negedge i_clk);
		i_pal_we = 1'b0;
		i_arst_n = 1'b1;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Output monitor, one call per falling edge
	////////////////////////////////////////////////////////////////////////////

	task automatic check_output_step();
		color_t got;
		int row;
		int col;
		got = {o_red, o_green, o_blue};
		check_level(o_csync_n, o_vid_hsync_n & o_vid_vsync_n, "o_csync_n");
		check_wide(o_vid_red, expand_component(o_red), "o_vid_red");
		check_wide(o_vid_green, expand_component(o_green), "o_vid_green");
		check_wide(o_vid_blue, expand_component(o_blue), "o_vid_blue");
		if (!started && !o_vid_ce)
			check_levels_idle("before the first pixel");
		// Black whenever either blank is active
		if (!o_vid_hblank_n || !o_vid_vblank_n)
			check_color(got, '0, "Blanked");
		if (o_vid_ce) begin
			started = 1'b1;
			pix_cnt++;
			// Only active pixels advance the picture position
			if (o_vid_hblank_n && o_vid_vblank_n) begin
				row = act_idx / H_ACTIVE;
				col = act_idx % H_ACTIVE;
				if (gold_color.exists(act_idx)) begin
					check_color(got, gold_color[act_idx],
						$sformatf("Row %0d column %0d", row, col));
					seen_cnt++;
				end
				act_idx++;
			end
			// Sync pulse edges, lines counted at each hsync start
			if (hs_prev && !o_vid_hsync_n) begin
				hs_falls++;
				if (!o_vid_vsync_n)
					vs_lines++;
			end
			if (vs_prev && !o_vid_vsync_n)
				vs_falls++;
			hs_prev = o_vid_hsync_n;
			vs_prev = o_vid_vsync_n;
		end
	endtask

	initial begin
		i_arst_n = 1'b0;
		i_pal_we = 1'b0;
		i_pal_addr = '0;
		i_pal_data = '0;
		gold_upper = 0;
		pix_cnt = 0;
		act_idx = 0;
		seen_cnt = 0;
		hs_falls = 0;
		vs_falls = 0;
		vs_lines = 0;
		hs_prev = 1'b1;
		vs_prev = 1'b1;
		started = 1'b0;
		load_golden();
		reset_and_load();
		// One whole frame from the first output pixel
		while (pix_cnt < FRAME_PIXELS) begin
			@(negedge i_clk);
			check_output_step();
		end
		check_count(act_idx, H_ACTIVE * V_ACTIVE, "active pixels per frame");
		check_count(hs_falls, V_TOTAL, "hsync pulses per frame");
		check_count(vs_falls, 1, "vsync pulses per frame");
		check_count(vs_lines, VS_LINES, "lines in the vsync pulse");
		if (seen_cnt == gold_color.num()) begin
			$display("Checked %0d golden samples, %0d in the upper bank", seen_cnt, gold_upper);
			$display("TESTS PASSED");
			$finish;
		end else begin
			fail_stop($sformatf("Only %0d of %0d golden samples were reached",
				seen_cnt, gold_color.num()));
		end
	end

	// Watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge i_clk);
		fail_stop("Timeout, the frame did not complete within two frame times");
	end

endmodule

`default_nettype wire

/* system86_video.f */
verilog/s86_video_pkg.sv
verilog/video_timing.sv
verilog/dot_pattern.sv
verilog/palette_lut.sv
verilog/video_out.sv
verilog/system86_video.sv
sim/tb_system86_video.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the System 86 video testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -Wno-fatal \
	-f system86_video.f --top-module tb_system86_video \
	-o tb_system86_video > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
# A non-zero simulator status counts as a failure in the log
./obj_dir/tb_system86_video > sim.log 2>&1 || echo "TESTS FAILED" >> sim.log
cat sim.log
grep -q "TESTS FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TESTS FAILED" sim.log || echo "Simulation passed"
exit 0

/* sim/system86_video_golden.txt */
# W <palette address hex> <colour rgb hex>
# C <row> <column> <expected colour rgb hex>
W 000 F00
W 01F 0F0
W 0E0 00F
W 0FF FFF
W 06B ABC
W 100 123
W 11F 456
W 16B DEF
W 1D0 5A3
W 1FF 789
C 0 0 F00
C 0 287 0F0
C 50 100 ABC
C 111 0 00F
C 111 287 FFF
C 112 0 123
C 112 287 456
C 162 100 DEF
C 200 150 5A3
C 223 287 789
